//--- afu_core.sv
`timescale 1ns/1ps

module afu_core import afu_pkg::*; (
	input  logic              CLK_400M,
	input  logic              reset_n,
	input  logic              core_start,
	input  logic [63:0]       io_src_ptr,
	input  logic [63:0]       io_dst_ptr,
	input  logic              rd_almostfull,
	input  logic              wr_almostfull,
	input  logic              rx_valid,
	input  logic [LINE_W-1:0] rx_data,
	output logic              tx_rd_valid,
	output logic [ADDR_W-1:0] tx_rd_addr,
	output logic              tx_wr_valid,
	output logic              tx_wr_fence,
	output logic [ADDR_W-1:0] tx_wr_addr,
	output logic [LINE_W-1:0] tx_data
);
	rx_beat_t          rx_beat;
	logic [LINE_W-1:0] head;
	logic              not_empty;
	logic              pop;
	logic              line_pop;
	logic              load_active;
	logic              batch_start;
	batch_cfg_t        batch_cfg;
	logic              batch_done;

	// polling, read issue and batch setup
	batch_ctrl ctrl_i (
		.CLK_400M      (CLK_400M),
		.reset_n       (reset_n),
		.core_start    (core_start),
		.io_src_ptr    (io_src_ptr),
		.io_dst_ptr    (io_dst_ptr),
		.rd_almostfull (rd_almostfull),
		.wr_almostfull (wr_almostfull),
		.rx_beat       (rx_beat),
		.line_pop      (line_pop),
		.batch_done    (batch_done),
		.tx_rd_valid   (tx_rd_valid),
		.tx_rd_addr    (tx_rd_addr),
		.load_active   (load_active),
		.batch_start   (batch_start),
		.batch_cfg     (batch_cfg)
	);

	// response register and load line FIFO
	line_buffer buf_i (
		.CLK_400M    (CLK_400M),
		.reset_n     (reset_n),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.load_active (load_active),
		.pop         (pop),
		.rx_beat     (rx_beat),
		.head        (head),
		.not_empty   (not_empty)
	);

	// output writes and batch close
	wr_sequencer wr_i (
		.CLK_400M      (CLK_400M),
		.reset_n       (reset_n),
		.rd_almostfull (rd_almostfull),
		.wr_almostfull (wr_almostfull),
		.batch_start   (batch_start),
		.batch_cfg     (batch_cfg),
		.head          (head),
		.not_empty     (not_empty),
		.pop           (pop),
		.line_pop      (line_pop),
		.batch_done    (batch_done),
		.tx_wr_valid   (tx_wr_valid),
		.tx_wr_fence   (tx_wr_fence),
		.tx_wr_addr    (tx_wr_addr),
		.tx_data       (tx_data)
	);

endmodule

//--- afu_pkg.sv
package afu_pkg;

	// ------------------------------------------------------------
	// widths and sizes
	// ------------------------------------------------------------
	localparam int LINE_W         = 512;
	localparam int ADDR_W         = 58;
	localparam int BATCH_W        = 7;
	localparam int LINE_CNT_W     = 9;
	localparam int LINES_PER_READ = 4;
	localparam int LINE_BUF_DEPTH = 4;
	localparam int LINE_BUF_PTR_W = $clog2(LINE_BUF_DEPTH);

	// ------------------------------------------------------------
	// handshake line layout
	// ------------------------------------------------------------
	// handshake line sits just below the input region
	localparam logic [ADDR_W-1:0] HAND_OFFSET  = 58'd50331648 + 58'd16384 - 58'd1;
	localparam logic [ADDR_W-1:0] INPUT_OFFSET = 58'd50331648 + 58'd16384;

	localparam int TAG0_BIT  = 480;
	localparam int TAG1_BIT  = 482;
	localparam int BATCH_LSB = 448;

	// completion code field runs from DONE_LSB to the top of the line
	localparam int DONE_LSB  = 480;
	localparam int DONE_CODE = 16;

	// ------------------------------------------------------------
	// types
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE,
		POLL_REQ,
		POLL_WAIT,
		LOAD,
		DRAIN
	} batch_state_e;

	typedef struct packed {
		logic              valid;
		logic [LINE_W-1:0] data;
	} rx_beat_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [LINE_W-1:0] data;
		logic              fence;
	} wr_req_t;

	// per-batch setup for the write side
	typedef struct packed {
		logic [LINE_CNT_W-1:0] line_cnt;
		logic [ADDR_W-1:0]     out_base;
		logic [ADDR_W-1:0]     hand_addr;
	} batch_cfg_t;

endpackage

//--- batch_ctrl.sv
`timescale 1ns/1ps

module batch_ctrl import afu_pkg::*; (
	input  logic              CLK_400M,
	input  logic              reset_n,
	input  logic              core_start,
	input  logic [63:0]       io_src_ptr,
	input  logic [63:0]       io_dst_ptr,
	input  logic              rd_almostfull,
	input  logic              wr_almostfull,
	input  rx_beat_t          rx_beat,
	input  logic              line_pop,
	input  logic              batch_done,
	output logic              tx_rd_valid,
	output logic [ADDR_W-1:0] tx_rd_addr,
	output logic              load_active,
	output logic              batch_start,
	output batch_cfg_t        batch_cfg
);
	batch_state_e            state;
	logic                    stall;
	logic                    parity;
	logic [ADDR_W-1:0]       hand_addr;
	logic [ADDR_W-1:0]       input_base;
	logic [ADDR_W-1:0]       out_base;
	logic [BATCH_W-1:0]      batch_size;
	logic [BATCH_W-1:0]      batch_size_in;
	logic [LINE_CNT_W-1:0]   line_cnt;
	logic [LINE_CNT_W-1:0]   load_ptr;
	logic [LINE_BUF_PTR_W:0] outstanding;
	logic                    tag_hit;
	logic                    accept;
	logic                    poll_issue;
	logic                    load_issue;

	// region pointers, relative to the host buffers
	always_ff @(posedge CLK_400M) begin
		hand_addr  <= io_src_ptr[ADDR_W-1:0] + HAND_OFFSET;
		input_base <= io_src_ptr[ADDR_W-1:0] + INPUT_OFFSET;
		out_base   <= io_dst_ptr[ADDR_W-1:0];
	end

	// local copy of the stall register
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			stall <= 1'b0;
		end else begin
			stall <= rd_almostfull | wr_almostfull;
		end
	end

	// ------------------------------------------------------------
	// handshake decode
	// ------------------------------------------------------------
	// ready tag alternates between bit 480 and bit 482 per batch
	assign tag_hit       = parity ? rx_beat.data[TAG1_BIT] : rx_beat.data[TAG0_BIT];
	assign batch_size_in = rx_beat.data[BATCH_LSB +: BATCH_W];
	assign accept        = (state == POLL_WAIT) && rx_beat.valid && tag_hit;
	assign line_cnt      = LINE_CNT_W'(batch_size * LINES_PER_READ);

	// ------------------------------------------------------------
	// read issue
	// ------------------------------------------------------------
	assign poll_issue  = (state == POLL_REQ) && !stall;
	assign load_issue  = (state == LOAD) && !stall && (load_ptr < line_cnt)
		&& (outstanding < LINE_BUF_DEPTH);
	assign load_active = (state == LOAD) || (state == DRAIN);

	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			tx_rd_valid <= 1'b0;
		end else begin
			tx_rd_valid <= poll_issue | load_issue;
		end
	end

	always_ff @(posedge CLK_400M) begin
		if (load_issue) begin
			tx_rd_addr <= input_base + ADDR_W'(load_ptr);
		end else if (poll_issue) begin
			tx_rd_addr <= hand_addr;
		end
	end

	// reads in flight or parked in the line buffer
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			outstanding <= '0;
		end else begin
			case ({load_issue, line_pop})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	// ------------------------------------------------------------
	// batch FSM
	// ------------------------------------------------------------
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			state       <= IDLE;
			parity      <= 1'b0;
			load_ptr    <= '0;
			batch_start <= 1'b0;
		end else begin
			batch_start <= 1'b0;
			case (state)
				IDLE: begin
					// parity survives IDLE on purpose
					if (core_start) begin
						state <= POLL_REQ;
					end
				end
				POLL_REQ: begin
					if (!stall) begin
						state <= POLL_WAIT;
					end
				end
				POLL_WAIT: begin
					if (accept) begin
						parity      <= ~parity;
						load_ptr    <= '0;
						batch_start <= 1'b1;
						state       <= LOAD;
					end else if (rx_beat.valid) begin
						state <= POLL_REQ;
					end
				end
				LOAD: begin
					if (load_issue) begin
						load_ptr <= load_ptr + 1'b1;
					end
					if (load_ptr == line_cnt) begin
						state <= DRAIN;
					end
				end
				DRAIN: begin
					if (batch_done) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// batch setup, handed to the write side with batch_start
	always_ff @(posedge CLK_400M) begin
		if (accept) begin
			batch_size          <= batch_size_in;
			batch_cfg.line_cnt  <= LINE_CNT_W'(batch_size_in * LINES_PER_READ);
			batch_cfg.out_base  <= out_base;
			batch_cfg.hand_addr <= hand_addr;
		end
	end

	// almost-full seen two edges back reaches the request through stall
	a_no_rd_in_stall: assert property (@(posedge CLK_400M) disable iff (!reset_n)
		tx_rd_valid |-> !$past(rd_almostfull | wr_almostfull, 2));

endmodule

//--- flist.f
afu_pkg.sv
batch_ctrl.sv
line_buffer.sv
wr_sequencer.sv
afu_core.sv
tb_host_model.sv
tb_afu_core.sv

//--- line_buffer.sv
`timescale 1ns/1ps

module line_buffer import afu_pkg::*; (
	input  logic              CLK_400M,
	input  logic              reset_n,
	input  logic              rx_valid,
	input  logic [LINE_W-1:0] rx_data,
	input  logic              load_active,
	input  logic              pop,
	output rx_beat_t          rx_beat,
	output logic [LINE_W-1:0] head,
	output logic              not_empty
);
	logic [LINE_W-1:0]       mem [LINE_BUF_DEPTH];
	logic [LINE_BUF_PTR_W:0] wr_ptr;
	logic [LINE_BUF_PTR_W:0] rd_ptr;
	logic                    push;
	logic                    full;

	// ------------------------------------------------------------
	// response register
	// ------------------------------------------------------------
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			rx_beat.valid <= 1'b0;
		end else begin
			rx_beat.valid <= rx_valid;
		end
	end

	always_ff @(posedge CLK_400M) begin
		rx_beat.data <= rx_data;
	end

	// ------------------------------------------------------------
	// load line FIFO
	// ------------------------------------------------------------
	// poll responses arrive outside LOAD and are not stored
	assign push = rx_beat.valid && load_active;

	// extra pointer bit tells full from empty
	assign not_empty = (wr_ptr != rd_ptr);
	assign full      = (wr_ptr[LINE_BUF_PTR_W] != rd_ptr[LINE_BUF_PTR_W])
		&& (wr_ptr[LINE_BUF_PTR_W-1:0] == rd_ptr[LINE_BUF_PTR_W-1:0]);
	assign head      = mem[rd_ptr[LINE_BUF_PTR_W-1:0]];

	always_ff @(posedge CLK_400M) begin
		if (push) begin
			mem[wr_ptr[LINE_BUF_PTR_W-1:0]] <= rx_beat.data;
		end
	end

	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// the outstanding limit in batch_ctrl keeps this from firing
	a_no_push_full: assert property (@(posedge CLK_400M) disable iff (!reset_n)
		push |-> !full);

endmodule

//--- tb_afu_core.sv
`timescale 1ns/1ps

module tb_afu_core import afu_pkg::*; ();
	logic               CLK_400M;
	logic               reset_n;
	logic               core_start;
	logic [63:0]        io_src_ptr;
	logic [63:0]        io_dst_ptr;
	logic               rd_almostfull;
	logic               wr_almostfull;
	logic               rx_valid;
	logic [LINE_W-1:0]  rx_data;
	logic               tx_rd_valid;
	logic [ADDR_W-1:0]  tx_rd_addr;
	logic               tx_wr_valid;
	logic               tx_wr_fence;
	logic [ADDR_W-1:0]  tx_wr_addr;
	logic [LINE_W-1:0]  tx_data;
	integer             seed;
	logic [BATCH_W-1:0] batch_size [2];
	int                 wait0;
	int                 wait1;
	int                 accepted;
	int                 err_cnt = 0;
	logic               cfg_done = 1'b0;
	logic               af_d1 = 1'b0;
	logic               af_d2 = 1'b0;
	int                 rd_batch = 0;
	int                 rd_idx = 0;
	int                 wr_idx = 0;
	int                 batch_end [2];
	logic [ADDR_W-1:0]  exp_addr [$];
	logic [LINE_W-1:0]  exp_data [$];
	logic               exp_fence [$];
	int                 exp_batch [$];

	afu_core dut_i (
		.CLK_400M(CLK_400M), .reset_n(reset_n), .core_start(core_start),
		.io_src_ptr(io_src_ptr), .io_dst_ptr(io_dst_ptr),
		.rd_almostfull(rd_almostfull), .wr_almostfull(wr_almostfull),
		.rx_valid(rx_valid), .rx_data(rx_data),
		.tx_rd_valid(tx_rd_valid), .tx_rd_addr(tx_rd_addr),
		.tx_wr_valid(tx_wr_valid), .tx_wr_fence(tx_wr_fence),
		.tx_wr_addr(tx_wr_addr), .tx_data(tx_data)
	);

	tb_host_model #(.SEED(32'h1deeb6c6)) host_i (
		.CLK_400M(CLK_400M), .reset_n(reset_n), .src_ptr(io_src_ptr),
		.size0(batch_size[0]), .size1(batch_size[1]), .wait0(wait0), .wait1(wait1),
		.tx_rd_valid(tx_rd_valid), .tx_rd_addr(tx_rd_addr),
		.rx_valid(rx_valid), .rx_data(rx_data),
		.rd_almostfull(rd_almostfull), .wr_almostfull(wr_almostfull),
		.accepted(accepted)
	);

	initial CLK_400M = 1'b0;
	always #50 CLK_400M = ~CLK_400M;

	task automatic check_value(input string name, input logic [LINE_W-1:0] actual,
		input logic [LINE_W-1:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			err_cnt++;
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		err_cnt++;
		$display("TB FAILED");
		$fatal(1, "protocol failure");
	endtask

	task automatic add_write(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] data,
		input logic fence, input int batch);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_fence.push_back(fence);
		exp_batch.push_back(batch);
	endtask

	// ------------------------------------------------------------
	// reference model of the write sequence
	// ------------------------------------------------------------
	task automatic build_expected();
		logic [ADDR_W-1:0] in_addr;
		logic [ADDR_W-1:0] out_addr;
		logic [ADDR_W-1:0] hand;
		logic [LINE_W-1:0] done_line;
		int                b;
		int                i;
		hand      = io_src_ptr[ADDR_W-1:0] + HAND_OFFSET;
		done_line = LINE_W'(DONE_CODE) << DONE_LSB;
		for (b = 0; b < 2; b++) begin
			for (i = 0; i < LINES_PER_READ * batch_size[b]; i++) begin
				in_addr  = io_src_ptr[ADDR_W-1:0] + INPUT_OFFSET + ADDR_W'(i);
				out_addr = io_dst_ptr[ADDR_W-1:0] + ADDR_W'(i);
				add_write(out_addr, host_i.line_at(in_addr), 1'b0, b);
			end
			add_write('0, '0, 1'b1, b);
			add_write(hand, done_line, 1'b0, b);
			add_write('0, '0, 1'b1, b);
			batch_end[b] = exp_addr.size();
		end
	endtask

	task automatic check_read();
		logic [ADDR_W-1:0] hand;
		logic [ADDR_W-1:0] load_addr;
		hand      = io_src_ptr[ADDR_W-1:0] + HAND_OFFSET;
		load_addr = io_src_ptr[ADDR_W-1:0] + INPUT_OFFSET + ADDR_W'(rd_idx);
		if (tx_rd_addr == hand) begin
			if (accepted != rd_batch || rd_idx != 0) begin
				report_failure("handshake polled after the ready tag was accepted");
			end else if (rd_batch > 0 && wr_idx != batch_end[rd_batch-1]) begin
				report_failure("handshake polled before the previous batch closed");
			end
		end else if (rd_batch >= 2 || accepted <= rd_batch) begin
			report_failure("load read outside an accepted batch");
		end else begin
			check_value("tx_rd_addr", tx_rd_addr, load_addr);
			rd_idx++;
			if (rd_idx == LINES_PER_READ * batch_size[rd_batch]) begin
				rd_batch++;
				rd_idx = 0;
			end
		end
	endtask

	task automatic check_write();
		if (wr_idx >= exp_addr.size()) begin
			report_failure("write beyond the expected sequence");
		end else if (exp_batch[wr_idx] >= accepted) begin
			report_failure("write issued before its batch was accepted");
		end else begin
			check_value("tx_wr_fence", tx_wr_fence, exp_fence[wr_idx]);
			check_value("tx_wr_addr", tx_wr_addr, exp_addr[wr_idx]);
			if (!exp_fence[wr_idx]) begin
				check_value("tx_data", tx_data, exp_data[wr_idx]);
			end
			wr_idx++;
		end
	endtask

	// outputs are sampled mid-cycle, stall is judged two cycles back
	always @(negedge CLK_400M) begin
		if (!reset_n) begin
			af_d1 = 1'b0;
			af_d2 = 1'b0;
		end else begin
			if ((tx_rd_valid || tx_wr_valid) && af_d2) begin
				report_failure("request or write issued while stalled");
			end
			if (tx_wr_fence && !tx_wr_valid) begin
				report_failure("fence flag raised without a write");
			end
			if (tx_rd_valid) begin
				check_read();
			end
			if (tx_wr_valid) begin
				check_write();
			end
			af_d2 = af_d1;
			af_d1 = rd_almostfull | wr_almostfull;
		end
	end

	// ------------------------------------------------------------
	// stimulus and end of run
	// ------------------------------------------------------------
	initial begin
		seed       = 32'h1deeb6c6;
		reset_n    = 1'b0;
		core_start = 1'b0;
		io_src_ptr = {$random(seed), $random(seed)};
		io_dst_ptr = {$random(seed), $random(seed)};
		batch_size[0] = 1 + ($unsigned($random(seed)) % 4);
		batch_size[1] = 1 + ($unsigned($random(seed)) % 4);
		wait0 = 2 + ($unsigned($random(seed)) % 4);
		wait1 = 2 + ($unsigned($random(seed)) % 4);
		build_expected();
		cfg_done = 1'b1;
		repeat (4) @(posedge CLK_400M);
		#1 reset_n = 1'b1;
		@(posedge CLK_400M);
		#1 core_start = 1'b1;
		wait (wr_idx == exp_addr.size());
		// stale tags must not start a third batch
		repeat (60) @(posedge CLK_400M);
		if (err_cnt == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "checks failed");
		end
	end

	initial begin
		wait (cfg_done);
		repeat (400 * exp_addr.size() + 2000) @(posedge CLK_400M);
		$display("Error at %0t: watchdog expired after %0d of %0d writes",
			$time, wr_idx, exp_addr.size());
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

endmodule

//--- tb_host_model.sv
`timescale 1ns/1ps

module tb_host_model import afu_pkg::*; #(
	parameter logic [31:0] SEED = 32'h1deeb6c6
) (
	input  logic               CLK_400M,
	input  logic               reset_n,
	input  logic [63:0]        src_ptr,
	input  logic [BATCH_W-1:0] size0,
	input  logic [BATCH_W-1:0] size1,
	input  int                 wait0,
	input  int                 wait1,
	input  logic               tx_rd_valid,
	input  logic [ADDR_W-1:0]  tx_rd_addr,
	output logic               rx_valid,
	output logic [LINE_W-1:0]  rx_data,
	output logic               rd_almostfull,
	output logic               wr_almostfull,
	output int                 accepted
);
	integer            seed = SEED;
	int                cycle = 0;
	int                last_due = 0;
	int                due;
	int                polls = 0;
	logic              in_reset;
	logic [31:0]       r;
	logic [ADDR_W-1:0] hand_addr;
	logic [ADDR_W-1:0] resp_addr;
	logic [LINE_W-1:0] resp_line;
	logic [ADDR_W-1:0] pend_addr [$];
	int                pend_due [$];

	assign hand_addr = src_ptr[ADDR_W-1:0] + HAND_OFFSET;

	// fixed scramble of the line address, eight 64 bit words
	function automatic logic [LINE_W-1:0] line_at(input logic [ADDR_W-1:0] addr);
		logic [63:0]       a;
		logic [LINE_W-1:0] line;
		int                k;
		a = {6'd0, addr};
		for (k = 0; k < 8; k++) begin
			line[64*k +: 64] = (a * (2*k + 3)) ^ {a[31:0], a[63:32]} ^ (64'h9e3779b97f4a7c15 + k);
		end
		return line;
	endfunction

	// idle levels until the first clock edge
	initial begin
		rx_valid      = 1'b0;
		rx_data       = '0;
		rd_almostfull = 1'b0;
		wr_almostfull = 1'b0;
	end

	// ------------------------------------------------------------
	// request capture, responses stay in order
	// ------------------------------------------------------------
	always @(negedge CLK_400M) begin
		if (reset_n && tx_rd_valid) begin
			due = cycle + 1 + ($unsigned($random(seed)) % 6);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			pend_addr.push_back(tx_rd_addr);
			pend_due.push_back(due);
		end
	end

	// ------------------------------------------------------------
	// response and almost-full drive
	// ------------------------------------------------------------
	always @(posedge CLK_400M) begin
		in_reset = !reset_n;
		#1;
		cycle++;
		rx_valid = 1'b0;
		rx_data  = '0;
		if (in_reset) begin
			rd_almostfull = 1'b0;
			wr_almostfull = 1'b0;
			accepted      = 0;
			polls         = 0;
			pend_addr.delete();
			pend_due.delete();
		end else begin
			// about one cycle in four has one of the two levels high
			r = $random(seed);
			rd_almostfull = (r[1:0] == 2'd0) && r[2];
			wr_almostfull = (r[1:0] == 2'd0) && !r[2];
			if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
				resp_addr = pend_addr.pop_front();
				void'(pend_due.pop_front());
				resp_line = line_at(resp_addr);
				if (resp_addr == hand_addr) begin
					// handshake line follows the batch plan
					resp_line = '0;
					if (accepted == 0) begin
						resp_line[BATCH_LSB +: BATCH_W] = size0;
						if (polls < wait0) begin
							polls++;
						end else begin
							resp_line[TAG0_BIT] = 1'b1;
							polls    = 0;
							accepted = 1;
						end
					end else if (accepted == 1) begin
						// stale tag at bit 480 stays set
						resp_line[BATCH_LSB +: BATCH_W] = size1;
						resp_line[TAG0_BIT] = 1'b1;
						if (polls < wait1) begin
							polls++;
						end else begin
							resp_line[TAG1_BIT] = 1'b1;
							polls    = 0;
							accepted = 2;
						end
					end else begin
						resp_line[BATCH_LSB +: BATCH_W] = size1;
						resp_line[TAG1_BIT] = 1'b1;
					end
				end
				rx_valid = 1'b1;
				rx_data  = resp_line;
			end
		end
	end

endmodule

//--- wr_sequencer.sv
`timescale 1ns/1ps

module wr_sequencer import afu_pkg::*; (
	input  logic              CLK_400M,
	input  logic              reset_n,
	input  logic              rd_almostfull,
	input  logic              wr_almostfull,
	input  logic              batch_start,
	input  batch_cfg_t        batch_cfg,
	input  logic [LINE_W-1:0] head,
	input  logic              not_empty,
	output logic              pop,
	output logic              line_pop,
	output logic              batch_done,
	output logic              tx_wr_valid,
	output logic              tx_wr_fence,
	output logic [ADDR_W-1:0] tx_wr_addr,
	output logic [LINE_W-1:0] tx_data
);
	typedef enum logic [2:0] {
		WR_IDLE,
		WR_LINES,
		WR_FENCE0,
		WR_DONE,
		WR_FENCE1
	} wr_state_e;

	wr_state_e             state;
	logic                  stall;
	batch_cfg_t            cfg;
	logic [LINE_CNT_W-1:0] line_idx;
	logic                  last_line;
	wr_req_t               wr_q;
	logic                  issue;
	logic                  fence_issue;
	logic [ADDR_W-1:0]     next_addr;
	logic [LINE_W-1:0]     next_data;
	logic [LINE_W-1:0]     done_line;

	// second stall copy, same rule as the read side
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			stall <= 1'b0;
		end else begin
			stall <= rd_almostfull | wr_almostfull;
		end
	end

	always_ff @(posedge CLK_400M) begin
		if (batch_start) begin
			cfg <= batch_cfg;
		end
	end

	assign last_line = (line_idx == cfg.line_cnt);
	assign pop       = (state == WR_LINES) && !last_line && !stall && not_empty;

	// ------------------------------------------------------------
	// next write select
	// ------------------------------------------------------------
	always_comb begin
		done_line = '0;
		done_line[LINE_W-1:DONE_LSB] = (LINE_W-DONE_LSB)'(DONE_CODE);
		issue       = 1'b0;
		fence_issue = 1'b0;
		next_addr   = '0;
		next_data   = '0;
		case (state)
			WR_LINES: begin
				issue     = pop;
				next_addr = cfg.out_base + ADDR_W'(line_idx);
				next_data = head;
			end
			// fences go to address 0 with an empty line
			WR_FENCE0, WR_FENCE1: begin
				issue       = !stall;
				fence_issue = !stall;
			end
			WR_DONE: begin
				issue     = !stall;
				next_addr = cfg.hand_addr;
				next_data = done_line;
			end
			default: issue = 1'b0;
		endcase
	end

	// ------------------------------------------------------------
	// write FSM and output register
	// ------------------------------------------------------------
	always_ff @(posedge CLK_400M) begin
		if (!reset_n) begin
			state       <= WR_IDLE;
			line_idx    <= '0;
			tx_wr_valid <= 1'b0;
			wr_q.fence  <= 1'b0;
			line_pop    <= 1'b0;
			batch_done  <= 1'b0;
		end else begin
			tx_wr_valid <= issue;
			wr_q.fence  <= fence_issue;
			line_pop    <= pop;
			batch_done  <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (batch_start) begin
						line_idx <= '0;
						state    <= WR_LINES;
					end
				end
				WR_LINES: begin
					if (pop) begin
						line_idx <= line_idx + 1'b1;
					end
					if (last_line) begin
						state <= WR_FENCE0;
					end
				end
				WR_FENCE0: if (!stall) state <= WR_DONE;
				WR_DONE:   if (!stall) state <= WR_FENCE1;
				WR_FENCE1: begin
					if (!stall) begin
						batch_done <= 1'b1;
						state      <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_400M) begin
		if (issue) begin
			wr_q.addr <= next_addr;
			wr_q.data <= next_data;
		end
	end

	assign tx_wr_fence = wr_q.fence;
	assign tx_wr_addr  = wr_q.addr;
	assign tx_data     = wr_q.data;

	a_fence_has_valid: assert property (@(posedge CLK_400M) disable iff (!reset_n)
		tx_wr_fence |-> tx_wr_valid);

endmodule
